// File: dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// cpu side sizes
`define DC_ADDR_WIDTH   32
`define DC_WORD_WIDTH   32

// line geometry, 16 bytes per line
`define DC_LINE_WORDS   4

// two ways only, lru is a single bit per set
`define DC_WAYS         2
`define DC_SETS         16

// address split: tag | index | byte offset
`define DC_OFFSET_WIDTH 4
`define DC_INDEX_WIDTH  4
`define DC_TAG_WIDTH    (`DC_ADDR_WIDTH - `DC_INDEX_WIDTH - `DC_OFFSET_WIDTH)

`endif

// File: dcache_pkg.sv
`include "dcache_config.svh"

`default_nettype none

package dcache_pkg;

    typedef logic [`DC_WORD_WIDTH-1:0] word_t;

    // one strobe per byte lane
    typedef logic [`DC_WORD_WIDTH/8-1:0] strb_t;

    // word 0 sits in the low bits
    typedef logic [`DC_LINE_WORDS*`DC_WORD_WIDTH-1:0] line_t;

    typedef logic [`DC_TAG_WIDTH-1:0] tag_t;
    typedef logic [`DC_INDEX_WIDTH-1:0] index_t;

    typedef struct packed {
        logic valid;   // line present
        logic dirty;   // line differs from memory
        tag_t tag;
    } tag_entry_t;

endpackage

`default_nettype wire

// File: cache_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

// one way of tag entries or data lines, indexed by set
module cache_ram #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = `DC_SETS
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               we,
    input  dcache_pkg::index_t waddr,
    input  entry_t             wdata,
    input  dcache_pkg::index_t raddr,
    output entry_t             rdata
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0; // all tags invalid after reset
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr]; // async read, lookup sees it same cycle

endmodule

`default_nettype wire

// File: dcache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_lookup (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   cpu_req,
    input  logic                                   cpu_we,
    input  logic                                   cpu_uncached,
    input  logic [`DC_ADDR_WIDTH-1:0]              cpu_addr,
    input  dcache_pkg::word_t                      cpu_wdata,
    input  dcache_pkg::strb_t                      cpu_wstrb,
    output logic                                   cpu_ack,
    output dcache_pkg::word_t                      cpu_rdata,
    input  dcache_pkg::tag_entry_t [`DC_WAYS-1:0]  tag_rdata,
    input  dcache_pkg::line_t [`DC_WAYS-1:0]       line_rdata,
    output dcache_pkg::index_t                     ram_index,
    output logic [`DC_WAYS-1:0]                    tag_we,
    output logic [`DC_WAYS-1:0]                    line_we,
    output dcache_pkg::tag_entry_t                 tag_wdata,
    output dcache_pkg::line_t                      line_wdata,
    output logic                                   fill_req,
    output logic                                   fill_dirty,
    output logic [`DC_ADDR_WIDTH-1:0]              fill_victim_addr,
    output logic [`DC_ADDR_WIDTH-1:0]              fill_addr,
    output dcache_pkg::line_t                      fill_victim_line,
    input  logic                                   fill_ack,
    input  dcache_pkg::line_t                      fill_line,
    output logic                                   unc_req,
    input  logic                                   unc_ack,
    input  dcache_pkg::word_t                      unc_rdata
);

    localparam int SEL_W = $clog2(`DC_LINE_WORDS);

    typedef enum logic [2:0] {
        S_IDLE,
        S_COMPARE,
        S_RESPOND,
        S_FILL,
        S_UNCACHED
    } state_t;

    state_t              state;
    dcache_pkg::tag_t    cpu_tag;
    logic [SEL_W-1:0]    word_sel;
    logic [`DC_WAYS-1:0] hit;
    logic                hit_way;
    logic                victim;
    logic [`DC_SETS-1:0] lru;         // per set, way to evict next
    logic                store_hit;
    logic                refill_wr;
    dcache_pkg::line_t   hit_line;
    dcache_pkg::line_t   merged_line;
    dcache_pkg::word_t   hit_word;

    // address fields, cpu holds them stable while req is up
    assign cpu_tag   = cpu_addr[`DC_ADDR_WIDTH-1 -: `DC_TAG_WIDTH];
    assign ram_index = cpu_addr[`DC_OFFSET_WIDTH +: `DC_INDEX_WIDTH];
    assign word_sel  = cpu_addr[2 +: SEL_W];

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit[w] = tag_rdata[w].valid && (tag_rdata[w].tag == cpu_tag);
        end
    end

    assign hit_way  = hit[1];          // two ways, one-hot to index
    assign victim   = lru[ram_index];
    assign hit_line = line_rdata[hit_way];
    assign hit_word = hit_line[word_sel*`DC_WORD_WIDTH +: `DC_WORD_WIDTH];

    // store bytes over the hit line
    always_comb begin
        merged_line = hit_line;
        for (int b = 0; b < `DC_WORD_WIDTH/8; b++) begin
            if (cpu_wstrb[b]) begin
                merged_line[word_sel*`DC_WORD_WIDTH + b*8 +: 8] = cpu_wdata[b*8 +: 8];
            end
        end
    end

    assign store_hit = (state == S_COMPARE) && cpu_we && (|hit);
    assign refill_wr = (state == S_FILL) && fill_req && fill_ack; // once, fill_req drops here

    always_comb begin
        tag_we  = '0;
        line_we = '0;
        if (refill_wr) begin
            tag_we[victim]  = 1'b1;
            line_we[victim] = 1'b1;
        end else if (store_hit) begin
            tag_we[hit_way]  = 1'b1;
            line_we[hit_way] = 1'b1;
        end
    end

    assign tag_wdata  = '{valid: 1'b1, dirty: !refill_wr, tag: cpu_tag}; // refill is clean
    assign line_wdata = refill_wr ? fill_line : merged_line;

    // victim payload, steady through the fill since lru only moves on a hit
    assign fill_dirty       = tag_rdata[victim].valid && tag_rdata[victim].dirty;
    assign fill_victim_addr = {tag_rdata[victim].tag, ram_index, {`DC_OFFSET_WIDTH{1'b0}}};
    assign fill_addr        = {cpu_tag, ram_index, {`DC_OFFSET_WIDTH{1'b0}}};
    assign fill_victim_line = line_rdata[victim];

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_IDLE;
            cpu_ack  <= 1'b0;
            fill_req <= 1'b0;
            unc_req  <= 1'b0;
            lru      <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cpu_req && cpu_uncached) begin
                        unc_req <= 1'b1;   // payload goes straight to uncached port
                        state   <= S_UNCACHED;
                    end else if (cpu_req) begin
                        state <= S_COMPARE;
                    end
                end
                S_COMPARE: begin
                    if (|hit) begin
                        lru[ram_index] <= !hit_way; // other way is now older
                        state          <= S_RESPOND;
                    end else begin
                        fill_req <= 1'b1;
                        state    <= S_FILL;
                    end
                end
                S_FILL: begin
                    if (fill_req && fill_ack) begin
                        fill_req <= 1'b0;
                    end else if (!fill_req && !fill_ack) begin
                        state <= S_COMPARE;   // retry, hits this time
                    end
                end
                S_UNCACHED: begin
                    if (unc_req && unc_ack) begin
                        unc_req <= 1'b0;
                    end else if (!unc_req && !unc_ack) begin
                        cpu_ack <= 1'b1;
                        state   <= S_RESPOND;
                    end
                end
                S_RESPOND: begin
                    if (!cpu_ack) begin
                        cpu_ack <= 1'b1;      // second edge after req on a hit
                    end else if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                        state   <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // read data held while cpu_ack is high
    always_ff @(posedge clk) begin
        if (state == S_COMPARE && (|hit)) begin
            cpu_rdata <= hit_word;
        end else if (state == S_UNCACHED && unc_req && unc_ack) begin
            cpu_rdata <= unc_rdata;
        end
    end

endmodule

`default_nettype wire

// File: line_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module line_engine (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      fill_req,
    input  logic                      fill_dirty,
    input  logic [`DC_ADDR_WIDTH-1:0] fill_victim_addr,
    input  logic [`DC_ADDR_WIDTH-1:0] fill_addr,
    input  dcache_pkg::line_t         fill_victim_line,
    output logic                      fill_ack,
    output dcache_pkg::line_t         fill_line,
    output logic                      m_req,
    output logic                      m_we,
    output logic [`DC_ADDR_WIDTH-1:0] m_addr,
    output dcache_pkg::line_t         m_wdata,
    input  logic                      m_ack,
    input  dcache_pkg::line_t         m_rdata
);

    typedef enum logic [2:0] {
        L_IDLE,
        L_WB,       // victim writeback in flight
        L_WB_END,   // wait ack low
        L_RD,       // refill read in flight
        L_RD_END,
        L_DONE
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= L_IDLE;
        end else begin
            case (state)
                L_IDLE:   if (fill_req) state <= fill_dirty ? L_WB : L_RD;
                L_WB:     if (m_ack) state <= L_WB_END;
                L_WB_END: if (!m_ack) state <= L_RD;
                L_RD:     if (m_ack) state <= L_RD_END;
                L_RD_END: if (!m_ack) state <= L_DONE;
                L_DONE:   if (!fill_req) state <= L_IDLE;
                default:  state <= L_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == L_RD && m_ack) begin
            fill_line <= m_rdata; // valid while ack high
        end
    end

    assign m_req    = (state == L_WB) || (state == L_RD);
    assign m_we     = (state == L_WB);
    assign m_addr   = m_we ? fill_victim_addr : fill_addr;
    assign m_wdata  = fill_victim_line;
    assign fill_ack = (state == L_DONE);

endmodule

`default_nettype wire

// File: uncached_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module uncached_port (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      unc_req,
    input  logic                      cpu_we,
    input  logic [`DC_ADDR_WIDTH-1:0] cpu_addr,
    input  dcache_pkg::word_t         cpu_wdata,
    input  dcache_pkg::strb_t         cpu_wstrb,
    output logic                      unc_ack,
    output dcache_pkg::word_t         unc_rdata,
    output logic                      m_req,
    output logic                      m_we,
    output logic [`DC_ADDR_WIDTH-1:0] m_addr,
    output dcache_pkg::word_t         m_wdata,
    output dcache_pkg::strb_t         m_wstrb,
    input  logic                      m_ack,
    input  dcache_pkg::word_t         m_rdata
);

    typedef enum logic [1:0] {U_IDLE, U_REQ, U_DONE} state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= U_IDLE;
        end else begin
            case (state)
                U_IDLE:  if (unc_req) state <= U_REQ;
                U_REQ:   if (m_ack) state <= U_DONE;
                U_DONE:  if (!unc_req && !m_ack) state <= U_IDLE; // both sides back to idle
                default: state <= U_IDLE;
            endcase
        end
    end

    // payload capture and read return
    always_ff @(posedge clk) begin
        if (state == U_IDLE && unc_req) begin
            m_we    <= cpu_we;
            m_addr  <= {cpu_addr[`DC_ADDR_WIDTH-1:2], 2'b00}; // word aligned
            m_wdata <= cpu_wdata;
            m_wstrb <= cpu_wstrb;
        end
        if (state == U_REQ && m_ack) begin
            unc_rdata <= m_rdata;
        end
    end

    assign m_req   = (state == U_REQ);
    assign unc_ack = (state == U_DONE); // one cycle after mem ack

endmodule

`default_nettype wire

// File: mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module mem_arbiter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      l_req,
    input  logic                      l_we,
    input  logic [`DC_ADDR_WIDTH-1:0] l_addr,
    input  dcache_pkg::line_t         l_wdata,
    output logic                      l_ack,
    output dcache_pkg::line_t         l_rdata,
    input  logic                      w_req,
    input  logic                      w_we,
    input  logic [`DC_ADDR_WIDTH-1:0] w_addr,
    input  dcache_pkg::word_t         w_wdata,
    input  dcache_pkg::strb_t         w_wstrb,
    output logic                      w_ack,
    output dcache_pkg::word_t         w_rdata,
    output logic                      mem_req,
    output logic                      mem_we,
    output logic                      mem_line,
    output logic [`DC_ADDR_WIDTH-1:0] mem_addr,
    output dcache_pkg::line_t         mem_wdata,
    output dcache_pkg::strb_t         mem_wstrb,
    input  logic                      mem_ack,
    input  dcache_pkg::line_t         mem_rdata
);

    logic busy;      // grant held
    logic owner;     // 0 line engine, 1 uncached port
    logic owner_req;

    assign owner_req = owner ? w_req : l_req;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            owner <= 1'b0;
        end else if (!busy) begin
            if (l_req) begin          // line engine wins a tie
                busy  <= 1'b1;
                owner <= 1'b0;
            end else if (w_req) begin
                busy  <= 1'b1;
                owner <= 1'b1;
            end
        end else if (!owner_req && !mem_ack) begin
            busy <= 1'b0;             // four-phase exchange finished
        end
    end

    assign mem_req   = busy && owner_req;
    assign mem_line  = !owner;
    assign mem_we    = owner ? w_we : l_we;
    assign mem_addr  = owner ? w_addr : l_addr;
    assign mem_wdata = owner ? dcache_pkg::line_t'(w_wdata) : l_wdata; // word in lane 0
    assign mem_wstrb = owner ? w_wstrb : '1;

    // ack only to the owner
    assign l_ack   = busy && !owner && mem_ack;
    assign w_ack   = busy && owner && mem_ack;
    assign l_rdata = mem_rdata;
    assign w_rdata = mem_rdata[`DC_WORD_WIDTH-1:0];

endmodule

`default_nettype wire

// File: dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cpu_req,
    input  logic                      cpu_we,
    input  logic                      cpu_uncached,
    input  logic [`DC_ADDR_WIDTH-1:0] cpu_addr,
    input  dcache_pkg::word_t         cpu_wdata,
    input  dcache_pkg::strb_t         cpu_wstrb,
    output logic                      cpu_ack,
    output dcache_pkg::word_t         cpu_rdata,
    output logic                      mem_req,
    output logic                      mem_we,
    output logic                      mem_line,
    output logic [`DC_ADDR_WIDTH-1:0] mem_addr,
    output dcache_pkg::line_t         mem_wdata,
    output dcache_pkg::strb_t         mem_wstrb,
    input  logic                      mem_ack,
    input  dcache_pkg::line_t         mem_rdata
);

    dcache_pkg::tag_entry_t [`DC_WAYS-1:0] tag_rdata;
    dcache_pkg::line_t [`DC_WAYS-1:0]      line_rdata;
    dcache_pkg::index_t                    ram_index;
    logic [`DC_WAYS-1:0]                   tag_we;
    logic [`DC_WAYS-1:0]                   line_we;
    dcache_pkg::tag_entry_t                tag_wdata;
    dcache_pkg::line_t                     line_wdata;

    // lookup to line engine
    logic                      fill_req;
    logic                      fill_dirty;
    logic [`DC_ADDR_WIDTH-1:0] fill_victim_addr;
    logic [`DC_ADDR_WIDTH-1:0] fill_addr;
    dcache_pkg::line_t         fill_victim_line;
    logic                      fill_ack;
    dcache_pkg::line_t         fill_line;

    // lookup to uncached port
    logic              unc_req;
    logic              unc_ack;
    dcache_pkg::word_t unc_rdata;

    // masters toward the arbiter
    logic                      l_req;
    logic                      l_we;
    logic [`DC_ADDR_WIDTH-1:0] l_addr;
    dcache_pkg::line_t         l_wdata;
    logic                      l_ack;
    dcache_pkg::line_t         l_rdata;
    logic                      w_req;
    logic                      w_we;
    logic [`DC_ADDR_WIDTH-1:0] w_addr;
    dcache_pkg::word_t         w_wdata;
    dcache_pkg::strb_t         w_wstrb;
    logic                      w_ack;
    dcache_pkg::word_t         w_rdata;

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        cache_ram #(.entry_t(dcache_pkg::tag_entry_t), .DEPTH(`DC_SETS)) tag_ram_i (
            .clk   (clk),
            .reset (reset),
            .we    (tag_we[w]),
            .waddr (ram_index),
            .wdata (tag_wdata),
            .raddr (ram_index),
            .rdata (tag_rdata[w])
        );
        cache_ram #(.entry_t(dcache_pkg::line_t), .DEPTH(`DC_SETS)) line_ram_i (
            .clk   (clk),
            .reset (reset),
            .we    (line_we[w]),
            .waddr (ram_index),
            .wdata (line_wdata),
            .raddr (ram_index),
            .rdata (line_rdata[w])
        );
    end

    dcache_lookup lookup_i (
        .clk, .reset,
        .cpu_req, .cpu_we, .cpu_uncached, .cpu_addr, .cpu_wdata, .cpu_wstrb,
        .cpu_ack, .cpu_rdata,
        .tag_rdata, .line_rdata, .ram_index, .tag_we, .line_we, .tag_wdata, .line_wdata,
        .fill_req, .fill_dirty, .fill_victim_addr, .fill_addr, .fill_victim_line,
        .fill_ack, .fill_line,
        .unc_req, .unc_ack, .unc_rdata
    );

    line_engine line_engine_i (
        .clk, .reset,
        .fill_req, .fill_dirty, .fill_victim_addr, .fill_addr, .fill_victim_line,
        .fill_ack, .fill_line,
        .m_req (l_req), .m_we (l_we), .m_addr (l_addr), .m_wdata (l_wdata),
        .m_ack (l_ack), .m_rdata (l_rdata)
    );

    // cpu payload goes straight in, lookup only hands over the request
    uncached_port uncached_port_i (
        .clk, .reset,
        .unc_req, .cpu_we, .cpu_addr, .cpu_wdata, .cpu_wstrb,
        .unc_ack, .unc_rdata,
        .m_req (w_req), .m_we (w_we), .m_addr (w_addr), .m_wdata (w_wdata),
        .m_wstrb (w_wstrb), .m_ack (w_ack), .m_rdata (w_rdata)
    );

    mem_arbiter mem_arbiter_i (
        .clk, .reset,
        .l_req, .l_we, .l_addr, .l_wdata, .l_ack, .l_rdata,
        .w_req, .w_we, .w_addr, .w_wdata, .w_wstrb, .w_ack, .w_rdata,
        .mem_req, .mem_we, .mem_line, .mem_addr, .mem_wdata, .mem_wstrb,
        .mem_ack, .mem_rdata
    );

endmodule

`default_nettype wire

// File: dcache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

// memory behind the shared bus, window of WORDS words from address 0
module dcache_mem_model #(
    parameter logic [31:0] PATTERN = 32'h0,
    parameter int          WORDS   = 1024
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      mem_req,
    input  logic                      mem_we,
    input  logic                      mem_line,
    input  logic [`DC_ADDR_WIDTH-1:0] mem_addr,
    input  dcache_pkg::line_t         mem_wdata,
    input  dcache_pkg::strb_t         mem_wstrb,
    output logic                      mem_ack,
    output dcache_pkg::line_t         mem_rdata
);

    dcache_pkg::word_t store [WORDS];
    int delay;
    int line_reads;
    int line_writes;

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            store[i] = dcache_pkg::word_t'(i * 4) ^ PATTERN; // word at byte address a holds a ^ pattern
        end
        line_reads  = 0;
        line_writes = 0;
    end

    function automatic dcache_pkg::word_t peek_word(input logic [31:0] addr);
        return store[addr[11:2]];
    endfunction

    task automatic serve;
        logic [9:0]        wa;
        dcache_pkg::word_t merged;
        dcache_pkg::line_t rd;
        wa = mem_addr[11:2];
        rd = '0;
        if (mem_line) begin
            for (int i = 0; i < `DC_LINE_WORDS; i++) begin
                if (mem_we) begin
                    store[wa + i] = mem_wdata[i*`DC_WORD_WIDTH +: `DC_WORD_WIDTH];
                end else begin
                    rd[i*`DC_WORD_WIDTH +: `DC_WORD_WIDTH] = store[wa + i];
                end
            end
            if (mem_we) line_writes++;
            else line_reads++;
        end else if (mem_we) begin
            merged = store[wa];
            for (int b = 0; b < 4; b++) begin
                if (mem_wstrb[b]) merged[b*8 +: 8] = mem_wdata[b*8 +: 8];
            end
            store[wa] = merged;
        end else begin
            rd[`DC_WORD_WIDTH-1:0] = store[wa]; // word in lane 0
        end
        mem_rdata <= rd;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            mem_ack <= 1'b0;
            delay   <= 0;
        end else if (mem_ack) begin
            if (!mem_req) mem_ack <= 1'b0;   // last phase
        end else if (mem_req) begin
            if (delay == 0) begin
                delay <= 1 + ($urandom % 6); // random wait
            end else if (delay == 1) begin
                serve();
                mem_ack <= 1'b1;
                delay   <= 0;
            end else begin
                delay <= delay - 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: dcache_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

// bus rules seen at the arbiter
module dcache_properties (
    input logic                      clk,
    input logic                      reset,
    input logic                      mem_req,
    input logic                      mem_we,
    input logic                      mem_line,
    input logic [`DC_ADDR_WIDTH-1:0] mem_addr,
    input dcache_pkg::line_t         mem_wdata,
    input dcache_pkg::strb_t         mem_wstrb,
    input logic                      mem_ack,
    input logic                      l_ack,
    input logic                      w_ack
);

    int err_count = 0; // polled by the testbench

    req_held: assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_ack |=> mem_req)
    else begin
        $error("mem_req dropped before mem_ack");
        err_count++;
    end

    payload_stable: assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_ack |=> $stable({mem_we, mem_line, mem_addr, mem_wdata, mem_wstrb}))
    else begin
        $error("memory payload changed while mem_req high");
        err_count++;
    end

    no_req_during_ack: assert property (@(posedge clk) disable iff (reset)
        $rose(mem_req) |-> !mem_ack)
    else begin
        $error("new mem_req while mem_ack still high");
        err_count++;
    end

    // every mem_ack lands on exactly one master
    one_owner_ack: assert property (@(posedge clk) disable iff (reset)
        $onehot0({l_ack, w_ack}) && ((l_ack || w_ack) == mem_ack))
    else begin
        $error("mem_ack not routed to exactly one master");
        err_count++;
    end

endmodule

bind mem_arbiter dcache_properties props_i (
    .clk, .reset, .mem_req, .mem_we, .mem_line, .mem_addr, .mem_wdata, .mem_wstrb,
    .mem_ack, .l_ack, .w_ack
);

`default_nettype wire

// File: tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module tb_dcache;

    localparam logic [31:0] PATTERN     = 32'h5a3c_96e1;
    localparam int          MEM_WORDS   = 1024;
    localparam int          CLK_PERIOD  = 4;
    localparam int          ACCESSES    = 240;  // directed plus random
    localparam int          WORST_MISS  = 40;   // writeback + refill, slowest memory
    localparam int          WATCHDOG_NS = (16 + ACCESSES * WORST_MISS) * CLK_PERIOD * 2;

    logic                      clk;
    logic                      reset;
    logic                      cpu_req;
    logic                      cpu_we;
    logic                      cpu_uncached;
    logic [`DC_ADDR_WIDTH-1:0] cpu_addr;
    dcache_pkg::word_t         cpu_wdata;
    dcache_pkg::strb_t         cpu_wstrb;
    logic                      cpu_ack;
    dcache_pkg::word_t         cpu_rdata;
    logic                      mem_req;
    logic                      mem_we;
    logic                      mem_line;
    logic [`DC_ADDR_WIDTH-1:0] mem_addr;
    dcache_pkg::line_t         mem_wdata;
    dcache_pkg::strb_t         mem_wstrb;
    logic                      mem_ack;
    dcache_pkg::line_t         mem_rdata;

    dcache_pkg::word_t shadow [MEM_WORDS]; // memory as the cpu sees it

    dcache_top dut_i (.*);

    dcache_mem_model #(.PATTERN(PATTERN), .WORDS(MEM_WORDS)) mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old_word,
            input dcache_pkg::word_t new_word, input dcache_pkg::strb_t strb);
        dcache_pkg::word_t w;
        w = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) w[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return w;
    endfunction

    // one four-phase exchange; latency counts edges from req sampled to ack raised
    task automatic cpu_access(input logic we, input logic unc, input logic [31:0] addr,
            input dcache_pkg::word_t wdata, input dcache_pkg::strb_t strb,
            output dcache_pkg::word_t rdata, output int latency);
        int edges;
        edges = 0;
        @(posedge clk);
        cpu_req      <= 1'b1;
        cpu_we       <= we;
        cpu_uncached <= unc;
        cpu_addr     <= addr;
        cpu_wdata    <= wdata;
        cpu_wstrb    <= strb;
        do begin
            @(posedge clk);
            edges++;
        end while (cpu_ack !== 1'b1);
        rdata   = cpu_rdata;   // held while ack high
        latency = edges - 2;   // minus sampling edge and observing edge
        cpu_req <= 1'b0;
        do @(posedge clk); while (cpu_ack !== 1'b0);
    endtask

    task automatic write_word(input logic unc, input logic [31:0] addr,
            input dcache_pkg::word_t data, input dcache_pkg::strb_t strb);
        dcache_pkg::word_t unused;
        int lat;
        cpu_access(1'b1, unc, addr, data, strb, unused, lat);
        shadow[addr[11:2]] = merge_bytes(shadow[addr[11:2]], data, strb);
    endtask

    task automatic read_word(input string name, input logic unc, input logic [31:0] addr,
            output int latency);
        dcache_pkg::word_t rd;
        cpu_access(1'b0, unc, addr, '0, '0, rd, latency);
        check_value(name, shadow[addr[11:2]], rd);
    endtask

    task automatic test_reset_idle;
        check_value("reset_cpu_ack", 0, cpu_ack);
        check_value("reset_mem_req", 0, mem_req);
        repeat (20) begin
            @(posedge clk);
            check_value("idle_cpu_ack", 0, cpu_ack);
            check_value("idle_mem_req", 0, mem_req);
        end
    endtask

    task automatic test_miss_then_hits;
        int reads;
        int lat;
        reads = mem_i.line_reads;
        read_word("miss_read", 1'b0, 32'h040, lat);
        check_value("miss_line_reads", reads + 1, mem_i.line_reads);
        for (int w = 1; w < `DC_LINE_WORDS; w++) begin
            read_word("hit_read", 1'b0, 32'h040 + w * 4, lat);
            check_value("hit_latency", 2, lat);
        end
        check_value("hit_line_reads", reads + 1, mem_i.line_reads); // no further refill
    endtask

    task automatic test_partial_store;
        int lat;
        write_word(1'b0, 32'h048, 32'hdead_beef, 4'b0101);
        read_word("store_readback", 1'b0, 32'h048, lat);
    endtask

    // set 4 again under two new tags, dirty line goes out
    task automatic test_dirty_eviction;
        int lat;
        read_word("evict_fill_a", 1'b0, 32'h148, lat);
        read_word("evict_fill_b", 1'b0, 32'h248, lat);
        check_value("evict_mem_word", shadow[32'h048 >> 2], mem_i.peek_word(32'h048));
        read_word("evict_reread", 1'b0, 32'h048, lat);
    endtask

    task automatic test_uncached;
        int xfers;
        int lat;
        xfers = mem_i.line_reads + mem_i.line_writes;
        write_word(1'b1, 32'h810, 32'h1234_5678, 4'b1100);
        read_word("uncached_read", 1'b1, 32'h810, lat);
        check_value("uncached_mem_word", shadow[32'h810 >> 2], mem_i.peek_word(32'h810));
        check_value("uncached_line_xfers", xfers, mem_i.line_reads + mem_i.line_writes);
    endtask

    // cached sets 0..3 with four tags, uncached words kept apart at 0x800
    task automatic test_random_mix;
        logic        unc;
        logic [31:0] addr;
        int          lat;
        for (int n = 0; n < 200; n++) begin
            unc = ($urandom % 4) == 0;
            if (unc) addr = 32'h800 | (($urandom % 64) << 2);
            else addr = (($urandom % 4) << 8) | (($urandom % 4) << 4) | (($urandom % 4) << 2);
            if ($urandom % 2) write_word(unc, addr, $urandom, $urandom % 16);
            else read_word("random_read", unc, addr, lat);
        end
    endtask

    initial begin
        void'($urandom(3428));
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = dcache_pkg::word_t'(i * 4) ^ PATTERN;
        end
        reset        = 1'b1;
        cpu_req      = 1'b0;
        cpu_we       = 1'b0;
        cpu_uncached = 1'b0;
        cpu_addr     = '0;
        cpu_wdata    = '0;
        cpu_wstrb    = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        test_reset_idle();
        test_miss_then_hits();
        test_partial_store();
        test_dirty_eviction();
        test_uncached();
        test_random_mix();
        repeat (4) @(posedge clk);
        if (dut_i.mem_arbiter_i.props_i.err_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            stop_on_error("memory bus assertion failed");
        end
    end

    // assertion failures stop the run at once
    always @(posedge clk) begin
        if (dut_i.mem_arbiter_i.props_i.err_count != 0) begin
            stop_on_error("memory bus assertion failed");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_error("timeout, the DUT stopped answering");
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
dcache_pkg.sv
cache_ram.sv
dcache_lookup.sv
line_engine.sv
uncached_port.sv
mem_arbiter.sv
dcache_top.sv
dcache_mem_model.sv
dcache_properties.sv
tb_dcache.sv
